/* tb.f */
source/cpu_pkg.sv
source/cpu_fetch.sv
source/cpu_decode.sv
source/cpu_register_file.sv
source/cpu_execute.sv
source/cpu_core.sv
dv/tb_cpu_core.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the pipeline testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_cpu_core > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_cpu_core > sim.log 2>&1
cat sim.log

grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation ended without a result"; exit 1; }

/* dv/tb_cpu_core.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the RV32I pipeline top level
// A register and PC model predicts each result, a monitor checks them in order
// Compiled from the tb.f file list, run by run.sh
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module tb_cpu_core;

	localparam logic [31:0] RESET_PC = 32'h0000_1000;
	localparam logic [6:0] OPCODE_OP = 7'b0110011;
	localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPCODE_LUI = 7'b0110111;
	localparam logic [6:0] OPCODE_AUIPC = 7'b0010111;
	localparam logic [6:0] OPCODE_JAL = 7'b1101111;
	localparam logic [6:0] OPCODE_JALR = 7'b1100111;
	localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
	localparam logic [6:0] OPCODE_LOAD = 7'b0000011;

	typedef struct packed {
		logic [31:0] pc;
		logic [4:0]  rd;
		logic [31:0] value;
		logic        write;
		logic        taken;
		logic [31:0] target;
	} expect_t;

	logic clock;
	logic reset;
	logic strobe;
	logic [31:0] instruction;
	logic result_strobe, result_write, branch_taken, fault;
	logic [4:0] result_rd;
	logic [31:0] result_value, result_pc, branch_target;

	logic [31:0] model_regs [0:31];
	logic [31:0] model_pc; // PC of the next word sent
	int squash_left; // Words still to be dropped after a taken branch
	logic [31:0] squash_target;
	expect_t expected [$];
	integer seed = 32'h2f77d576;

	cpu_core #(.RESET_PC(RESET_PC)) i_dut (
		.i_clock(clock), .i_reset(reset), .i_strobe(strobe), .i_instruction(instruction),
		.o_result_strobe(result_strobe), .o_result_write(result_write),
		.o_result_rd(result_rd), .o_result_value(result_value), .o_result_pc(result_pc),
		.o_branch_taken(branch_taken), .o_branch_target(branch_target), .o_fault(fault)
	);

	initial clock = 1'b0;
	always #2 clock = ~clock;

	task automatic stop_with_failure(input string line);
		$display("%s", line);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string msg);
		stop_with_failure($sformatf("error at %0t ns: %s", $time, msg));
	endtask

	// Instruction formats of the RV32I base set
	function automatic logic [31:0] r_type_word(input logic [6:0] funct7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd);
		return {funct7, rs2, rs1, funct3, rd, OPCODE_OP};
	endfunction

	function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] funct3, input logic [4:0] rd, input logic [6:0] opcode);
		return {imm, rs1, funct3, rd, opcode};
	endfunction

	function automatic logic [31:0] b_type_word(input logic [12:0] offset, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] funct3);
		return {offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11], OPCODE_BRANCH};
	endfunction

	function automatic logic [31:0] j_type_word(input logic [20:0] offset, input logic [4:0] rd);
		return {offset[20], offset[10:1], offset[11], offset[19:12], rd, OPCODE_JAL};
	endfunction

	function automatic logic [31:0] expected_alu(input logic [2:0] funct3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (funct3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return {31'd0, $signed(a) < $signed(b)};
			3'b011: return {31'd0, a < b};
			3'b100: return a ^ b;
			3'b101: begin
				if (alt)
					return $signed(a) >>> b[4:0]; // Sign bit shifted in
				return a >> b[4:0];
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_outcome(input logic [2:0] funct3, input logic [31:0] a,
		input logic [31:0] b);
		case (funct3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic logic [4:0] pick_register();
		logic [31:0] random_word;
		random_word = $random(seed);
		return {2'b00, random_word[2:0]} + 5'd1; // x1 to x8
	endfunction

	task automatic reset_model();
		for (int i = 0; i < 32; i++)
			model_regs[i] = 32'd0;
		model_pc = RESET_PC;
		squash_left = 0;
		expected.delete();
	endtask

	// Drives one word on the next edge, live is low when the pipeline will squash it
	task automatic send_word(input logic [31:0] word, output logic live, output logic [31:0] pc);
		@(posedge clock);
		strobe <= 1'b1;
		instruction <= word;
		pc = model_pc;
		live = (squash_left == 0);
		if (live) begin
			model_pc = model_pc + 32'd4;
		end else begin
			squash_left = squash_left - 1;
			if (squash_left == 0)
				model_pc = squash_target; // Third word after the branch
		end
	endtask

	task automatic retire(input logic [31:0] pc, input logic [4:0] rd, input logic has_rd,
		input logic [31:0] value, input logic taken, input logic [31:0] target);
		expect_t entry;
		entry.pc = pc;
		entry.rd = rd;
		entry.value = value;
		entry.write = has_rd && rd != 5'd0;
		entry.taken = taken;
		entry.target = target;
		expected.push_back(entry);
		if (entry.write)
			model_regs[rd] = value;
		if (taken) begin
			squash_left = 2;
			squash_target = target;
		end
	endtask

	task automatic issue_op(input logic [2:0] funct3, input logic alt, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		logic live;
		logic [31:0] pc;
		send_word(r_type_word({1'b0, alt, 5'd0}, rs2, rs1, funct3, rd), live, pc);
		if (live)
			retire(pc, rd, 1'b1, expected_alu(funct3, alt, model_regs[rs1], model_regs[rs2]),
				1'b0, 32'd0);
	endtask

	task automatic issue_imm(input logic [2:0] funct3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
		logic live;
		logic [31:0] pc;
		logic shift;
		shift = funct3 == 3'b001 || funct3 == 3'b101;
		send_word(i_type_word(imm, rs1, funct3, rd, OPCODE_OP_IMM), live, pc);
		if (live && shift)
			retire(pc, rd, 1'b1, expected_alu(funct3, imm[10], model_regs[rs1], {27'd0, imm[4:0]}),
				1'b0, 32'd0);
		else if (live)
			retire(pc, rd, 1'b1,
				expected_alu(funct3, 1'b0, model_regs[rs1], {{20{imm[11]}}, imm}), 1'b0, 32'd0);
	endtask

	task automatic issue_upper(input logic auipc, input logic [4:0] rd, input logic [19:0] imm);
		logic live;
		logic [31:0] pc;
		send_word({imm, rd, auipc ? OPCODE_AUIPC : OPCODE_LUI}, live, pc);
		if (live)
			retire(pc, rd, 1'b1, {imm, 12'd0} + (auipc ? pc : 32'd0), 1'b0, 32'd0);
	endtask

	task automatic issue_branch(input logic [2:0] funct3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] offset);
		logic live;
		logic [31:0] pc;
		send_word(b_type_word(offset, rs2, rs1, funct3), live, pc);
		if (live)
			retire(pc, 5'd0, 1'b0, 32'd0, branch_outcome(funct3, model_regs[rs1], model_regs[rs2]),
				pc + {{19{offset[12]}}, offset});
	endtask

	task automatic issue_jal(input logic [4:0] rd, input logic [20:0] offset);
		logic live;
		logic [31:0] pc;
		send_word(j_type_word(offset, rd), live, pc);
		if (live)
			retire(pc, rd, 1'b1, pc + 32'd4, 1'b1, pc + {{11{offset[20]}}, offset});
	endtask

	task automatic issue_jalr(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		logic live;
		logic [31:0] pc;
		logic [31:0] target;
		target = model_regs[rs1] + {{20{imm[11]}}, imm};
		target[0] = 1'b0;
		send_word(i_type_word(imm, rs1, 3'b000, rd, OPCODE_JALR), live, pc);
		if (live)
			retire(pc, rd, 1'b1, pc + 32'd4, 1'b1, target);
	endtask

	task automatic load_constant(input logic [4:0] rd, input logic [31:0] value);
		issue_upper(1'b0, rd, value[31:12] + {19'd0, value[11]}); // ADDI below sign extends
		issue_imm(3'b000, rd, rd, value[11:0]);
	endtask

	// Counts in x30 only when it is not squashed
	task automatic send_filler();
		issue_imm(3'b000, 5'd30, 5'd30, 12'd1);
	endtask

	task automatic wait_drained();
		int cycles;
		@(posedge clock);
		strobe <= 1'b0;
		cycles = 0;
		while (expected.size() != 0 && cycles < 20) begin
			@(negedge clock);
			cycles++;
		end
		assert (expected.size() == 0)
			else stop_with_failure("timed out waiting for the expected results");
		repeat (2) @(negedge clock);
	endtask

	task automatic apply_reset();
		@(posedge clock);
		reset <= 1'b1;
		strobe <= 1'b0;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		reset_model();
	endtask

	always @(negedge clock) begin
		expect_t entry;
		if (!reset && result_strobe) begin
			assert (expected.size() > 0)
				else stop_with_failure($sformatf("unexpected result for pc %h", result_pc));
			entry = expected.pop_front();
			assert (result_pc == entry.pc)
				else report_mismatch($sformatf("result pc %h, expected %h", result_pc, entry.pc));
			assert (result_write == entry.write)
				else report_mismatch($sformatf("write flag %b at pc %h", result_write, entry.pc));
			if (entry.write) begin
				assert (result_rd == entry.rd)
					else report_mismatch($sformatf("rd %0d at pc %h, expected %0d", result_rd,
						entry.pc, entry.rd));
				assert (result_value == entry.value)
					else report_mismatch($sformatf("value %h at pc %h, expected %h", result_value,
						entry.pc, entry.value));
			end
			assert (branch_taken == entry.taken)
				else report_mismatch($sformatf("taken %b at pc %h", branch_taken, entry.pc));
			if (entry.taken)
				assert (branch_target == entry.target)
					else report_mismatch($sformatf("target %h at pc %h, expected %h",
						branch_target, entry.pc, entry.target));
		end else if (!reset) begin
			assert (!branch_taken) else stop_with_failure("branch taken without a result strobe");
		end
	end

	task automatic check_reset_and_latency();
		int cycles;
		@(negedge clock);
		assert (!result_strobe && !result_write && !branch_taken && !fault && result_rd == 5'd0
			&& result_value == 32'd0 && result_pc == 32'd0 && branch_target == 32'd0)
			else report_mismatch("outputs not cleared by reset");
		issue_imm(3'b000, 5'd1, 5'd0, 12'h5a5);
		cycles = 0;
		do begin
			@(posedge clock);
			strobe <= 1'b0;
			cycles++;
			@(negedge clock);
		end while (!result_strobe && cycles < 10);
		assert (cycles == 3)
			else report_mismatch($sformatf("first result after %0d cycles, expected 3", cycles));
		assert (result_pc == RESET_PC)
			else report_mismatch($sformatf("first pc %h, expected %h", result_pc, RESET_PC));
		wait_drained();
	endtask

	task automatic check_alu_ops();
		logic [31:0] random_word;
		logic [2:0] funct3;
		logic [11:0] imm;
		for (int round = 0; round < 4; round++) begin
			for (int r = 1; r <= 8; r++)
				load_constant(5'(r), $random(seed));
			for (int op = 0; op < 10; op++) begin
				funct3 = (op < 8) ? 3'(op) : ((op == 8) ? 3'b000 : 3'b101); // SUB, SRA last
				issue_op(funct3, op >= 8, pick_register(), pick_register(), pick_register());
			end
			for (int op = 0; op < 9; op++) begin
				random_word = $random(seed);
				funct3 = (op < 8) ? 3'(op) : 3'b101;
				imm = random_word[11:0];
				if (funct3 == 3'b001 || funct3 == 3'b101)
					imm = {1'b0, op == 8, 5'd0, random_word[4:0]}; // SRAI when op is 8
				issue_imm(funct3, pick_register(), pick_register(), imm);
			end
		end
		wait_drained();
	endtask

	task automatic check_upper_and_x0();
		issue_upper(1'b0, 5'd9, 20'habcde);
		issue_upper(1'b1, 5'd10, 20'h12345);
		issue_imm(3'b000, 5'd0, 5'd9, 12'h7ff); // Write to x0 reports no write
		issue_op(3'b000, 1'b0, 5'd11, 5'd0, 5'd9);
		issue_op(3'b110, 1'b0, 5'd12, 5'd0, 5'd0);
		wait_drained();
	endtask

	task automatic check_branches();
		logic [31:0] random_word;
		logic [4:0] rs1, rs2;
		for (int c = 0; c < 6; c++) begin
			load_constant(5'd10, $random(seed));
			load_constant(5'd11, $random(seed));
			// Swapped and equal operands give each condition both outcomes
			for (int pair = 0; pair < 3; pair++) begin
				random_word = $random(seed);
				rs1 = (pair == 1) ? 5'd11 : 5'd10;
				rs2 = (pair == 0) ? 5'd11 : 5'd10;
				issue_branch(3'(c < 2 ? c : c + 2), rs1, rs2,
					{{5{random_word[8]}}, random_word[7:2], 2'b00});
				send_filler();
				send_filler();
			end
		end
		issue_op(3'b000, 1'b0, 5'd12, 5'd30, 5'd0);
		wait_drained();
	endtask

	task automatic check_jumps();
		logic [31:0] random_word;
		random_word = $random(seed);
		issue_jal(5'd1, {{10{random_word[11]}}, random_word[10:2], 2'b00});
		send_filler();
		send_filler();
		issue_op(3'b000, 1'b0, 5'd13, 5'd1, 5'd0);
		issue_upper(1'b0, 5'd3, 20'h00002);
		issue_imm(3'b000, 5'd3, 5'd3, 12'h004);
		issue_jalr(5'd2, 5'd3, 12'h00d); // Odd sum, bit 0 cleared
		send_filler();
		send_filler();
		issue_op(3'b000, 1'b0, 5'd14, 5'd2, 5'd0);
		wait_drained();
	endtask

	task automatic check_fault();
		logic live;
		logic [31:0] pc;
		assert (!fault) else report_mismatch("fault set before any load");
		issue_imm(3'b000, 5'd15, 5'd0, 12'h0f0);
		send_word(i_type_word(12'd0, 5'd15, 3'b010, 5'd16, OPCODE_LOAD), live, pc); // LW
		issue_imm(3'b000, 5'd17, 5'd15, 12'h001);
		wait_drained();
		for (int i = 0; i < 5; i++) begin
			@(negedge clock);
			assert (fault) else report_mismatch("fault low after a load");
		end
		apply_reset();
		@(negedge clock);
		assert (!fault) else report_mismatch("fault still set after reset");
		issue_imm(3'b000, 5'd1, 5'd1, 12'h001); // x1 held a link value before the reset
		wait_drained();
	endtask

	initial begin
		strobe = 1'b0;
		instruction = 32'd0;
		reset = 1'b1;
		reset_model();
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		check_reset_and_latency();
		check_alu_ops();
		check_upper_and_x0();
		check_branches();
		check_jumps();
		check_fault();
		if (expected.size() == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			stop_with_failure("results still expected at the end of the run");
		end
	end

endmodule

`default_nettype wire

/* source/cpu_core.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Top of the RV32I integer pipeline
// Takes one instruction word per cycle, reports results three edges later
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module cpu_core #(
	parameter logic [31:0] RESET_PC = 32'h0000_1000
) (
	input  wire logic                i_clock,
	input  wire logic                i_reset,
	input  wire logic                i_strobe,
	input  wire cpu_pkg::word_t      i_instruction,
	output wire logic                o_result_strobe,
	output wire logic                o_result_write,
	output wire cpu_pkg::reg_index_t o_result_rd,
	output wire cpu_pkg::word_t      o_result_value,
	output wire cpu_pkg::word_t      o_result_pc,
	output wire logic                o_branch_taken,
	output wire cpu_pkg::word_t      o_branch_target,
	output wire logic                o_fault
);
	import cpu_pkg::*;

	// Fetch to decode
	wire logic f_strobe;
	wire word_t f_pc;
	wire word_t f_instruction;
	wire reg_index_t f_rs1, f_rs2, f_rd;

	// Decode to execute
	wire logic d_strobe;
	wire word_t d_pc;
	wire reg_index_t d_rs1, d_rs2, d_rd;
	wire word_t d_imm;
	wire alu_op_t d_alu_op;
	wire operand_sel_t d_operand1, d_operand2;
	wire logic d_write_rd, d_jump, d_jalr, d_branch;
	wire branch_cond_t d_branch_cond;

	wire word_t read_data1, read_data2;

	// The taken branch output doubles as the flush for fetch and decode
	cpu_fetch #(.RESET_PC(RESET_PC)) u_fetch (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_strobe(i_strobe), .i_instruction(i_instruction),
		.i_redirect(o_branch_taken), .i_redirect_target(o_branch_target),
		.o_f_strobe(f_strobe), .o_f_pc(f_pc), .o_f_instruction(f_instruction),
		.o_f_rs1(f_rs1), .o_f_rs2(f_rs2), .o_f_rd(f_rd)
	);

	cpu_decode u_decode (
		.i_clock(i_clock), .i_reset(i_reset), .i_redirect(o_branch_taken),
		.i_f_strobe(f_strobe), .i_f_pc(f_pc), .i_f_instruction(f_instruction),
		.i_f_rs1(f_rs1), .i_f_rs2(f_rs2), .i_f_rd(f_rd),
		.o_fault(o_fault), .o_d_strobe(d_strobe), .o_d_pc(d_pc),
		.o_d_rs1(d_rs1), .o_d_rs2(d_rs2), .o_d_rd(d_rd), .o_d_imm(d_imm),
		.o_d_alu_op(d_alu_op), .o_d_operand1(d_operand1), .o_d_operand2(d_operand2),
		.o_d_write_rd(d_write_rd), .o_d_jump(d_jump), .o_d_jalr(d_jalr),
		.o_d_branch(d_branch), .o_d_branch_cond(d_branch_cond)
	);

	// Result write flag is already qualified by the result strobe
	cpu_register_file u_register_file (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_read_index1(d_rs1), .i_read_index2(d_rs2),
		.i_write_enable(o_result_write), .i_write_index(o_result_rd),
		.i_write_data(o_result_value),
		.o_read_data1(read_data1), .o_read_data2(read_data2)
	);

	cpu_execute u_execute (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_d_strobe(d_strobe), .i_d_pc(d_pc),
		.i_d_rs1(d_rs1), .i_d_rs2(d_rs2), .i_d_rd(d_rd), .i_d_imm(d_imm),
		.i_d_alu_op(d_alu_op), .i_d_operand1(d_operand1), .i_d_operand2(d_operand2),
		.i_d_write_rd(d_write_rd), .i_d_jump(d_jump), .i_d_jalr(d_jalr),
		.i_d_branch(d_branch), .i_d_branch_cond(d_branch_cond),
		.i_read_data1(read_data1), .i_read_data2(read_data2),
		.o_result_strobe(o_result_strobe), .o_result_write(o_result_write),
		.o_result_rd(o_result_rd), .o_result_value(o_result_value),
		.o_result_pc(o_result_pc),
		.o_branch_taken(o_branch_taken), .o_branch_target(o_branch_target)
	);

endmodule

`default_nettype wire

/* source/cpu_execute.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Execute and writeback stage
// Bypasses its own result register, runs the ALU and resolves branches
// The result register also drives the register file write port
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module cpu_execute (
	input  wire logic                  i_clock,
	input  wire logic                  i_reset,
	input  wire logic                  i_d_strobe,
	input  wire cpu_pkg::word_t        i_d_pc,
	input  wire cpu_pkg::reg_index_t   i_d_rs1,
	input  wire cpu_pkg::reg_index_t   i_d_rs2,
	input  wire cpu_pkg::reg_index_t   i_d_rd,
	input  wire cpu_pkg::word_t        i_d_imm,
	input  wire cpu_pkg::alu_op_t      i_d_alu_op,
	input  wire cpu_pkg::operand_sel_t i_d_operand1,
	input  wire cpu_pkg::operand_sel_t i_d_operand2,
	input  wire logic                  i_d_write_rd,
	input  wire logic                  i_d_jump,
	input  wire logic                  i_d_jalr,
	input  wire logic                  i_d_branch,
	input  wire cpu_pkg::branch_cond_t i_d_branch_cond,
	input  wire cpu_pkg::word_t        i_read_data1,
	input  wire cpu_pkg::word_t        i_read_data2,
	output logic                       o_result_strobe,
	output logic                       o_result_write,
	output cpu_pkg::reg_index_t        o_result_rd,
	output cpu_pkg::word_t             o_result_value,
	output cpu_pkg::word_t             o_result_pc,
	output logic                       o_branch_taken,
	output cpu_pkg::word_t             o_branch_target
);
	import cpu_pkg::*;

	word_t rs1_value, rs2_value;
	word_t operand1, operand2;
	word_t alu_result;
	word_t target;
	logic condition;
	logic taken;
	logic valid;

	function automatic word_t select_operand(input operand_sel_t sel, input word_t rs,
		input word_t pc, input word_t imm);
		case (sel)
			RS: return rs;
			PC: return pc;
			IMM: return imm;
			default: return '0;
		endcase
	endfunction

	// Previous result is not in the register file yet
	assign rs1_value = (o_result_write && o_result_rd == i_d_rs1) ? o_result_value : i_read_data1;
	assign rs2_value = (o_result_write && o_result_rd == i_d_rs2) ? o_result_value : i_read_data2;

	assign operand1 = select_operand(i_d_operand1, rs1_value, i_d_pc, i_d_imm);
	assign operand2 = select_operand(i_d_operand2, rs2_value, i_d_pc, i_d_imm);

	always_comb begin
		case (i_d_alu_op)
			ADD: alu_result = operand1 + operand2;
			SUB: alu_result = operand1 - operand2;
			SLL: alu_result = operand1 << operand2[4:0];
			SLT: alu_result = {31'd0, $signed(operand1) < $signed(operand2)};
			SLTU: alu_result = {31'd0, operand1 < operand2};
			XOR: alu_result = operand1 ^ operand2;
			SRL: alu_result = operand1 >> operand2[4:0];
			SRA: alu_result = $signed(operand1) >>> operand2[4:0];
			OR: alu_result = operand1 | operand2;
			AND: alu_result = operand1 & operand2;
			default: alu_result = operand2; // PASS2
		endcase
	end

	always_comb begin
		case (i_d_branch_cond)
			BEQ: condition = rs1_value == rs2_value;
			BNE: condition = rs1_value != rs2_value;
			BLT: condition = $signed(rs1_value) < $signed(rs2_value);
			BGE: condition = $signed(rs1_value) >= $signed(rs2_value);
			BLTU: condition = rs1_value < rs2_value;
			BGEU: condition = rs1_value >= rs2_value;
			default: condition = 1'b0;
		endcase
	end

	assign taken = i_d_branch ? condition : i_d_jump;
	assign target = i_d_jalr ? {alu_result[31:1], 1'b0} : alu_result;

	// Word behind a taken branch was fetched on the wrong path
	assign valid = i_d_strobe && !o_branch_taken;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_result_strobe <= 1'b0;
			o_result_write <= 1'b0;
			o_result_rd <= '0;
			o_result_value <= '0;
			o_result_pc <= '0;
			o_branch_taken <= 1'b0;
			o_branch_target <= '0;
		end else begin
			o_result_strobe <= valid;
			o_result_write <= valid && i_d_write_rd;
			o_result_rd <= i_d_rd;
			o_result_value <= i_d_jump ? i_d_pc + 32'd4 : alu_result; // Link value
			o_result_pc <= i_d_pc;
			o_branch_taken <= valid && taken;
			o_branch_target <= target;
		end
	end

	a_taken_has_result: assert property (@(posedge i_clock) disable iff (i_reset)
		o_branch_taken |-> o_result_strobe)
		else $error("branch taken without a result strobe");

endmodule

`default_nettype wire

/* source/cpu_register_file.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Integer register file, x1 to x31 plus a hardwired x0
// Two combinational read ports, one write port on the clock edge
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module cpu_register_file (
	input  wire logic                i_clock,
	input  wire logic                i_reset,
	input  wire cpu_pkg::reg_index_t i_read_index1,
	input  wire cpu_pkg::reg_index_t i_read_index2,
	input  wire logic                i_write_enable,
	input  wire cpu_pkg::reg_index_t i_write_index,
	input  wire cpu_pkg::word_t      i_write_data,
	output cpu_pkg::word_t           o_read_data1,
	output cpu_pkg::word_t           o_read_data2
);
	import cpu_pkg::*;

	word_t registers [1:31]; // x0 has no storage

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			for (int i = 1; i < 32; i++)
				registers[i] <= '0;
		end else if (i_write_enable && i_write_index != 5'd0) begin
			registers[i_write_index] <= i_write_data;
		end
	end

	assign o_read_data1 = (i_read_index1 == 5'd0) ? '0 : registers[i_read_index1];
	assign o_read_data2 = (i_read_index2 == 5'd0) ? '0 : registers[i_read_index2];

endmodule

`default_nettype wire

/* source/cpu_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Decode stage between fetch and execute
// Builds the immediate, the ALU controls and the class flags of one word
// Loads, stores and unknown opcodes raise a fault held until reset
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module cpu_decode (
	input  wire logic                  i_clock,
	input  wire logic                  i_reset,
	input  wire logic                  i_redirect,
	input  wire logic                  i_f_strobe,
	input  wire cpu_pkg::word_t        i_f_pc,
	input  wire cpu_pkg::word_t        i_f_instruction,
	input  wire cpu_pkg::reg_index_t   i_f_rs1,
	input  wire cpu_pkg::reg_index_t   i_f_rs2,
	input  wire cpu_pkg::reg_index_t   i_f_rd,
	output logic                       o_fault,
	output logic                       o_d_strobe,
	output cpu_pkg::word_t             o_d_pc,
	output cpu_pkg::reg_index_t        o_d_rs1,
	output cpu_pkg::reg_index_t        o_d_rs2,
	output cpu_pkg::reg_index_t        o_d_rd,
	output cpu_pkg::word_t             o_d_imm,
	output cpu_pkg::alu_op_t           o_d_alu_op,
	output cpu_pkg::operand_sel_t      o_d_operand1,
	output cpu_pkg::operand_sel_t      o_d_operand2,
	output logic                       o_d_write_rd,
	output logic                       o_d_jump,
	output logic                       o_d_jalr,
	output logic                       o_d_branch,
	output cpu_pkg::branch_cond_t      o_d_branch_cond
);
	import cpu_pkg::*;

	inst_t inst;
	word_t imm_i, imm_shift, imm_b, imm_j, imm_u;
	word_t imm;
	alu_op_t alu_op;
	operand_sel_t operand1, operand2;
	logic known;
	logic has_rd;
	logic is_shift;
	logic jump, jalr, branch;
	logic accept;

	// funct3 picks the operation, alt is funct7 bit 5 where it matters
	function automatic alu_op_t alu_from_funct3(input logic [2:0] funct3, input logic alt);
		case (funct3)
			3'b000: return alt ? SUB : ADD;
			3'b001: return SLL;
			3'b010: return SLT;
			3'b011: return SLTU;
			3'b100: return XOR;
			3'b101: return alt ? SRA : SRL;
			3'b110: return OR;
			default: return AND;
		endcase
	endfunction

	assign inst = i_f_instruction;
	assign accept = i_f_strobe && !i_redirect; // Younger word dies on a redirect

	assign imm_i = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
	assign imm_shift = {27'd0, inst.r.rs2}; // shamt sits in the rs2 field
	assign imm_b = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11, inst.b.imm_10_5,
		inst.b.imm_4_1, 1'b0};
	assign imm_j = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12, inst.j.imm_11,
		inst.j.imm_10_1, 1'b0};
	assign imm_u = {inst.u.imm_31_12, 12'd0};
	assign is_shift = inst.i.funct3[1:0] == 2'b01; // SLLI, SRLI, SRAI

	always_comb begin
		known = 1'b1;
		has_rd = 1'b0;
		imm = '0;
		alu_op = ADD;
		operand1 = RS;
		operand2 = RS;
		jump = 1'b0;
		jalr = 1'b0;
		branch = 1'b0;
		case (opcode_t'(inst.r.opcode))
			OP: begin
				has_rd = 1'b1;
				alu_op = alu_from_funct3(inst.r.funct3, inst.r.funct7[5]);
			end
			OP_IMM: begin
				has_rd = 1'b1;
				operand2 = IMM;
				imm = is_shift ? imm_shift : imm_i;
				alu_op = alu_from_funct3(inst.i.funct3, is_shift && inst.r.funct7[5]);
			end
			LUI: begin
				has_rd = 1'b1;
				operand1 = ZERO;
				operand2 = IMM;
				imm = imm_u;
				alu_op = PASS2;
			end
			AUIPC: begin
				has_rd = 1'b1;
				operand1 = PC;
				operand2 = IMM;
				imm = imm_u;
			end
			JAL: begin
				has_rd = 1'b1;
				jump = 1'b1;
				operand1 = PC; // ALU forms the target
				operand2 = IMM;
				imm = imm_j;
			end
			JALR: begin
				has_rd = 1'b1;
				jump = 1'b1;
				jalr = 1'b1;
				operand2 = IMM;
				imm = imm_i;
			end
			BRANCH: begin
				branch = 1'b1;
				operand1 = PC; // Compare runs beside the ALU
				operand2 = IMM;
				imm = imm_b;
			end
			LOAD, STORE: known = 1'b0; // No memory port
			default: known = 1'b0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_d_strobe <= 1'b0;
			o_fault <= 1'b0;
		end else begin
			o_d_strobe <= accept && known;
			if (accept && !known)
				o_fault <= 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		o_d_pc <= i_f_pc;
		o_d_rs1 <= i_f_rs1;
		o_d_rs2 <= i_f_rs2;
		o_d_rd <= i_f_rd;
		o_d_imm <= imm;
		o_d_alu_op <= alu_op;
		o_d_operand1 <= operand1;
		o_d_operand2 <= operand2;
		o_d_write_rd <= has_rd && (i_f_rd != 5'd0);
		o_d_jump <= jump;
		o_d_jalr <= jalr;
		o_d_branch <= branch;
		o_d_branch_cond <= branch_cond_t'(inst.b.funct3);
	end

	a_jump_not_branch: assert property (@(posedge i_clock) disable iff (i_reset)
		o_d_strobe |-> !(o_d_jump && o_d_branch))
		else $error("decode flagged jump and branch together");

endmodule

`default_nettype wire

/* source/cpu_fetch.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Fetch stage, first register of the pipeline
// Tags each incoming word with its PC and splits out the register fields
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module cpu_fetch #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  wire logic                i_clock,
	input  wire logic                i_reset,
	input  wire logic                i_strobe,
	input  wire cpu_pkg::word_t      i_instruction,
	input  wire logic                i_redirect,
	input  wire cpu_pkg::word_t      i_redirect_target,
	output logic                     o_f_strobe,
	output cpu_pkg::word_t           o_f_pc,
	output cpu_pkg::word_t           o_f_instruction,
	output cpu_pkg::reg_index_t      o_f_rs1,
	output cpu_pkg::reg_index_t      o_f_rs2,
	output cpu_pkg::reg_index_t      o_f_rd
);
	import cpu_pkg::*;

	word_t pc_counter; // PC for the next accepted word
	word_t word_pc;
	inst_t word;

	assign word = i_instruction;

	// A word taken while redirecting already belongs to the new stream
	assign word_pc = i_redirect ? i_redirect_target : pc_counter;

	// Squashing of the two words already past this stage is done in decode and execute
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			pc_counter <= RESET_PC;
			o_f_strobe <= 1'b0;
		end else begin
			o_f_strobe <= i_strobe;
			if (i_strobe)
				pc_counter <= word_pc + 32'd4;
			else if (i_redirect)
				pc_counter <= i_redirect_target; // Next word starts at the target
		end
	end

	always_ff @(posedge i_clock) begin
		o_f_pc <= word_pc;
		o_f_instruction <= i_instruction;
		o_f_rs1 <= word.r.rs1;
		o_f_rs2 <= word.r.rs2;
		o_f_rd <= word.r.rd;
	end

	// Redirect targets come from execute and must keep word alignment
	a_pc_aligned: assert property (@(posedge i_clock) disable iff (i_reset)
		o_f_strobe |-> o_f_pc[1:0] == 2'b00)
		else $error("fetch PC %h not word aligned", o_f_pc);

endmodule

`default_nettype wire

/* source/cpu_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Types and encodings shared by the RV32I pipeline stages
// Stages import it in their bodies and use scoped names on their ports
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_index_t;

	// Major opcodes, bits [6:0] of the instruction
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011
	} opcode_t;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		SLL,
		SLT,
		SLTU,
		XOR,
		SRL,
		SRA,
		OR,
		AND,
		PASS2 // Second operand straight through
	} alu_op_t;

	typedef enum logic [1:0] {
		RS,
		PC,
		IMM,
		ZERO
	} operand_sel_t;

	// Same values as funct3 of the branch group
	typedef enum logic [2:0] {
		BEQ  = 3'b000,
		BNE  = 3'b001,
		BLT  = 3'b100,
		BGE  = 3'b101,
		BLTU = 3'b110,
		BGEU = 3'b111
	} branch_cond_t;

	typedef struct packed {
		logic [6:0] funct7;
		reg_index_t rs2;
		reg_index_t rs1;
		logic [2:0] funct3;
		reg_index_t rd;
		logic [6:0] opcode;
	} inst_r_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		reg_index_t  rs1;
		logic [2:0]  funct3;
		reg_index_t  rd;
		logic [6:0]  opcode;
	} inst_i_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		reg_index_t rs2;
		reg_index_t rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} inst_s_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		reg_index_t rs2;
		reg_index_t rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} inst_b_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		reg_index_t  rd;
		logic [6:0]  opcode;
	} inst_u_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		reg_index_t rd;
		logic [6:0] opcode;
	} inst_j_t;

	// One instruction word seen through every format layout
	typedef union packed {
		inst_r_t r;
		inst_i_t i;
		inst_s_t s;
		inst_b_t b;
		inst_u_t u;
		inst_j_t j;
	} inst_t;

endpackage

`default_nettype wire
